//--- rtl/ds18b20_pkg.sv
package ds18b20_pkg;

    // ********************************************************************
    // Function commands
    // ********************************************************************
    localparam logic [7:0] CMD_SKIP_ROM     = 8'hCC;
    localparam logic [7:0] CMD_CONVERT_T    = 8'h44;
    localparam logic [7:0] CMD_READ_SCRATCH = 8'hBE;

    // Scratchpad, the last byte is its CRC
    localparam int SCRATCH_BYTES = 9;
    localparam int SCRATCH_BITS  = SCRATCH_BYTES * 8;

    // ********************************************************************
    // Transaction sequencer states
    // ********************************************************************
    typedef enum logic [3:0] {
        IDLE         = 4'd0,
        RESET1       = 4'd1,
        SKIP_ROM     = 4'd2,
        CONVERT_TEMP = 4'd3,
        WAIT_CONV    = 4'd4,
        RESET2       = 4'd5,
        SKIP_ROM2    = 4'd6,
        READ_SCRATCH = 4'd7,
        READ         = 4'd8,
        DONE         = 4'd9
    } seq_state_t;

endpackage

//--- rtl/onewire_op_if.sv
`timescale 1ns/1ps

interface onewire_op_if import onewire_pkg::*; ();

    // Request side
    logic        op_start;  // One cycle
    onewire_op_t op;
    logic        wr_bit;

    // Completion side
    logic        op_done;   // One cycle, once per start
    logic        rd_bit;    // Valid with op_done on reads
    logic        presence;  // Valid with op_done on resets

    modport seq (
        output op_start,
        output op,
        output wr_bit,
        input  op_done,
        input  rd_bit,
        input  presence
    );

    modport slot (
        input  op_start,
        input  op,
        input  wr_bit,
        output op_done,
        output rd_bit,
        output presence
    );

endinterface

//--- rtl/onewire_pkg.sv
package onewire_pkg;

    // ********************************************************************
    // Slot operations issued by the sequencer
    // ********************************************************************
    typedef enum logic [2:0] {
        OP_RESET     = 3'd0,
        OP_WRITE_BIT = 3'd1,
        OP_READ_BIT  = 3'd2,
        OP_WAIT      = 3'd3
    } onewire_op_t;

    // ********************************************************************
    // Bus timing in clock cycles, scaled down for simulation
    // ********************************************************************

    // Reset and presence
    localparam logic [15:0] T_RESET_LOW       = 16'd48;
    localparam logic [15:0] T_PRESENCE_SAMPLE = 16'd10;  // Counted from release
    localparam logic [15:0] T_RESET_TOTAL     = 16'd96;

    // Bit slots
    localparam logic [15:0] T_SLOT            = 16'd30;
    localparam logic [15:0] T_WRITE1_LOW      = 16'd3;
    localparam logic [15:0] T_WRITE0_LOW      = 16'd24;
    localparam logic [15:0] T_READ_LOW        = 16'd2;
    localparam logic [15:0] T_READ_SAMPLE     = 16'd6;   // Before the slave releases
    localparam logic [15:0] T_RECOVERY        = 16'd2;

    // Fixed temperature conversion time
    localparam logic [15:0] T_CONVERT         = 16'd400;

endpackage

//--- rtl/onewire_slot.sv
`timescale 1ns/1ps

module onewire_slot import onewire_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    onewire_op_if.slot op,
    input  logic       dq_in,
    output logic       dq_drive_low,
    output logic       bit_strobe,
    output logic       bit_value
);

    logic        active;
    logic        accept;
    onewire_op_t cur_op;
    logic [15:0] cnt;        // Cycles since op_start
    logic [15:0] low_len;
    logic [15:0] slot_len;
    logic [15:0] sample_at;
    logic [15:0] start_low;
    logic [15:0] start_len;
    logic [15:0] start_sample;

    assign accept = op.op_start && !active;

    // ********************************************************************
    // Slot shape for the requested operation
    // ********************************************************************
    always_comb begin
        start_low    = 16'd0;
        start_len    = T_SLOT + T_RECOVERY;
        start_sample = T_READ_SAMPLE;
        case (op.op)
            OP_RESET: begin
                start_low    = T_RESET_LOW;
                start_len    = T_RESET_TOTAL;
                start_sample = T_RESET_LOW + T_PRESENCE_SAMPLE;
            end
            OP_WRITE_BIT: start_low = op.wr_bit ? T_WRITE1_LOW : T_WRITE0_LOW;
            OP_READ_BIT:  start_low = T_READ_LOW;
            OP_WAIT:      start_len = T_CONVERT;  // Line left released
            default:      start_low = 16'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cur_op    <= op.op;
            low_len   <= start_low;
            slot_len  <= start_len;
            sample_at <= start_sample;
        end
    end

    // ********************************************************************
    // Slot timing
    // ********************************************************************
    assign op.op_done = active && cnt == slot_len;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            active       <= 1'b0;
            cnt          <= 16'd0;
            dq_drive_low <= 1'b0;
        end else if (active) begin
            cnt          <= cnt + 16'd1;
            dq_drive_low <= cnt < low_len && !op.op_done;
            if (op.op_done)
                active <= 1'b0;
        end else if (accept) begin
            active       <= 1'b1;
            cnt          <= 16'd1;
            dq_drive_low <= op.op != OP_WAIT;  // Low from the next cycle on
        end
    end

    // Presence and data sampling
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            op.presence <= 1'b0;
            op.rd_bit   <= 1'b0;
        end else if (active && cnt == sample_at) begin
            if (cur_op == OP_RESET)
                op.presence <= !dq_in;  // Slave pulls low
            else if (cur_op == OP_READ_BIT)
                op.rd_bit <= dq_in;
        end
    end

    // Read bits go straight to the result block
    assign bit_strobe = op.op_done && cur_op == OP_READ_BIT;
    assign bit_value  = op.rd_bit;

    // Conversion wait keeps the bus released
    a_wait_released: assert property (@(posedge clk) disable iff (rst)
        (active && cur_op == OP_WAIT) |-> !dq_drive_low);

endmodule

//--- rtl/temp_reader_top.sv
`timescale 1ns/1ps

module temp_reader_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        read_request,
    input  logic        dq_in,         // Sampled bus level
    output logic        dq_drive_low,  // Open-drain enable
    output logic        busy,
    output logic        temp_valid,
    output logic [15:0] temperature,
    output logic        crc_error,
    output logic        no_device
);

    logic first_bit;
    logic last_bit;
    logic bit_strobe;
    logic bit_value;

    onewire_op_if op_bus ();

    temp_sensor u_seq (
        .clk          (clk),
        .rst          (rst),
        .read_request (read_request),
        .busy         (busy),
        .op           (op_bus.seq),
        .first_bit    (first_bit),
        .last_bit     (last_bit),
        .no_device    (no_device)
    );

    onewire_slot u_slot (
        .clk          (clk),
        .rst          (rst),
        .op           (op_bus.slot),
        .dq_in        (dq_in),
        .dq_drive_low (dq_drive_low),
        .bit_strobe   (bit_strobe),
        .bit_value    (bit_value)
    );

    temp_result u_result (
        .clk          (clk),
        .rst          (rst),
        .first_bit    (first_bit),
        .last_bit     (last_bit),
        .bit_strobe   (bit_strobe),
        .bit_value    (bit_value),
        .temp_valid   (temp_valid),
        .crc_error    (crc_error),
        .temperature  (temperature)
    );

endmodule

//--- rtl/temp_result.sv
`timescale 1ns/1ps

module temp_result import ds18b20_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        first_bit,
    input  logic        last_bit,
    input  logic        bit_strobe,
    input  logic        bit_value,
    output logic        temp_valid,
    output logic        crc_error,
    output logic [15:0] temperature
);

    logic [SCRATCH_BITS-1:0] scratch;  // Byte 0 ends up in the low bits
    logic [7:0]              crc;
    logic                    fb;
    logic                    armed;    // Between first_bit and last_bit

    assign fb = crc[0] ^ bit_value;

    // Scratchpad shift register, LSB first on the wire
    always_ff @(posedge clk) begin
        if (bit_strobe)
            scratch <= {bit_value, scratch[SCRATCH_BITS-1:1]};
        if (last_bit)
            temperature <= scratch[15:0];
    end

    // ********************************************************************
    // Serial CRC-8, x^8 + x^5 + x^4 + 1
    // ********************************************************************
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            crc        <= 8'd0;
            armed      <= 1'b0;
            temp_valid <= 1'b0;
            crc_error  <= 1'b0;
        end else begin
            temp_valid <= last_bit;
            crc_error  <= last_bit && crc != 8'd0;  // Zero over data plus CRC byte
            if (first_bit) begin
                crc   <= 8'd0;
                armed <= 1'b1;
            end else if (bit_strobe) begin
                crc <= {1'b0, crc[7:1]} ^ (fb ? 8'h8C : 8'h00);
            end
            if (last_bit)
                armed <= 1'b0;
        end
    end

    // Sequencer always opens a read before closing it
    a_first_before_last: assert property (@(posedge clk) disable iff (rst)
        last_bit |-> armed);

endmodule

//--- rtl/temp_sensor.sv
`timescale 1ns/1ps

module temp_sensor import onewire_pkg::*, ds18b20_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       read_request,
    output logic       busy,
    onewire_op_if.seq  op,
    output logic       first_bit,
    output logic       last_bit,
    output logic       no_device
);

    seq_state_t  state;
    seq_state_t  after_byte;
    onewire_op_t next_op;
    logic [7:0]  cmd_byte;
    logic [2:0]  bit_cnt;
    logic [6:0]  read_cnt;
    logic        pending;    // Operation in flight in the slot engine
    logic        can_issue;
    logic        issue;

    // ********************************************************************
    // Per-state command byte and operation
    // ********************************************************************
    always_comb begin
        cmd_byte   = CMD_SKIP_ROM;
        after_byte = CONVERT_TEMP;
        case (state)
            CONVERT_TEMP: begin
                cmd_byte   = CMD_CONVERT_T;
                after_byte = WAIT_CONV;
            end
            SKIP_ROM2:    after_byte = READ_SCRATCH;
            READ_SCRATCH: begin
                cmd_byte   = CMD_READ_SCRATCH;
                after_byte = READ;
            end
            default:      after_byte = CONVERT_TEMP;
        endcase
    end

    always_comb begin
        next_op   = OP_WAIT;
        can_issue = 1'b1;
        case (state)
            RESET1, RESET2:                 next_op = OP_RESET;
            SKIP_ROM, CONVERT_TEMP,
            SKIP_ROM2, READ_SCRATCH:        next_op = OP_WRITE_BIT;
            WAIT_CONV:                      next_op = OP_WAIT;
            READ:                           next_op = OP_READ_BIT;
            default:                        can_issue = 1'b0;
        endcase
    end

    assign issue = can_issue && !pending && !op.op_start;

    // Operation payload, sent LSB first
    always_ff @(posedge clk) begin
        if (issue) begin
            op.op     <= next_op;
            op.wr_bit <= cmd_byte[bit_cnt];
        end
    end

    // ********************************************************************
    // Sequencer FSM
    // ********************************************************************
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            busy        <= 1'b0;
            op.op_start <= 1'b0;
            pending     <= 1'b0;
            bit_cnt     <= 3'd0;
            read_cnt    <= 7'd0;
            first_bit   <= 1'b0;
            last_bit    <= 1'b0;
            no_device   <= 1'b0;
        end else begin
            op.op_start <= issue;
            first_bit   <= issue && state == READ && read_cnt == 7'd0;
            last_bit    <= 1'b0;
            no_device   <= 1'b0;

            if (op.op_start)
                pending <= 1'b1;
            else if (op.op_done)
                pending <= 1'b0;

            case (state)
                IDLE: if (read_request) begin
                    busy  <= 1'b1;
                    state <= RESET1;
                end
                RESET1, RESET2: if (op.op_done) begin
                    if (!op.presence) begin  // Nobody on the bus
                        no_device <= 1'b1;
                        busy      <= 1'b0;
                        state     <= IDLE;
                    end else begin
                        bit_cnt <= 3'd0;
                        state   <= (state == RESET1) ? SKIP_ROM : SKIP_ROM2;
                    end
                end
                SKIP_ROM, CONVERT_TEMP, SKIP_ROM2, READ_SCRATCH: if (op.op_done) begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        read_cnt <= 7'd0;
                        state    <= after_byte;
                    end
                end
                WAIT_CONV: if (op.op_done) state <= RESET2;
                READ: if (op.op_done) begin
                    read_cnt <= read_cnt + 7'd1;
                    if (read_cnt == 7'(SCRATCH_BITS - 1)) begin
                        last_bit <= 1'b1;
                        state    <= DONE;
                    end
                end
                DONE: begin
                    busy  <= 1'b0;  // Falls with the result pulse
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Slot engine never sees a second start before its done
    a_one_outstanding: assert property (@(posedge clk) disable iff (rst)
        op.op_start |-> !pending);

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module tb_temp_reader -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -qxF '** PASS **' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- src.f
rtl/onewire_pkg.sv
rtl/ds18b20_pkg.sv
rtl/onewire_op_if.sv
rtl/temp_sensor.sv
rtl/onewire_slot.sv
rtl/temp_result.sv
rtl/temp_reader_top.sv
testbench/temp_checker.sv
testbench/tb_temp_reader.sv

//--- testbench/tb_temp_reader.sv
`timescale 1ns/1ps

module tb_temp_reader import onewire_pkg::*, ds18b20_pkg::*; ();

    localparam int WAIT_LIMIT = 20000;  // Cycles per transaction

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    read_request;
    logic                    dq_in;
    logic                    dq_drive_low;
    logic                    busy;
    logic                    temp_valid;
    logic [15:0]             temperature;
    logic                    crc_error;
    logic                    no_device;

    logic                    slave_low = 1'b0;
    logic                    present;
    logic [SCRATCH_BITS-1:0] scratch;
    logic [7:0]              cmd_log [$];
    logic [7:0]              rx_byte = 8'd0;
    int                      rx_cnt = 0;
    int                      low_cnt = 0;
    int                      pull_left = 0;
    int                      rd_idx = 0;
    logic                    reading = 1'b0;

    integer                  seed;
    int                      fail_cnt;
    int                      timeouts;
    int                      results_before;
    int                      checks;
    int                      mismatches;
    int                      results;

    always #10 clk = ~clk;

    assign dq_in = !(dq_drive_low || slave_low);  // Open-drain bus with pull-up

    temp_reader_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .read_request (read_request),
        .dq_in        (dq_in),
        .dq_drive_low (dq_drive_low),
        .busy         (busy),
        .temp_valid   (temp_valid),
        .temperature  (temperature),
        .crc_error    (crc_error),
        .no_device    (no_device)
    );

    temp_checker checker_i (
        .clk         (clk),
        .rst         (rst),
        .present     (present),
        .scratch     (scratch),
        .busy        (busy),
        .temp_valid  (temp_valid),
        .crc_error   (crc_error),
        .temperature (temperature),
        .no_device   (no_device),
        .checks      (checks),
        .mismatches  (mismatches),
        .results     (results)
    );

    // ********************************************************************
    // Sensor model timing the master's low pulses
    // ********************************************************************
    always @(posedge clk) begin
        if (pull_left != 0)
            pull_left = pull_left - 1;
        if (dq_drive_low && low_cnt == 0 && reading && present) begin  // Read slot opens
            if (!scratch[rd_idx])
                pull_left = int'(T_READ_SAMPLE) + 4;
            rd_idx = rd_idx + 1;
            if (rd_idx == SCRATCH_BITS)
                reading = 1'b0;
        end
        if (dq_drive_low) begin
            low_cnt = low_cnt + 1;
        end else if (low_cnt != 0) begin
            if (low_cnt >= int'(T_RESET_LOW) - 8) begin
                reading = 1'b0;
                rx_cnt  = 0;
                if (present)
                    pull_left = 2 * int'(T_PRESENCE_SAMPLE);  // Presence pulse
            end else if (!reading && present) begin
                rx_byte = {low_cnt < int'(T_WRITE0_LOW) / 2, rx_byte[7:1]};  // LSB first
                rx_cnt  = rx_cnt + 1;
                if (rx_cnt == 8) begin
                    cmd_log.push_back(rx_byte);
                    rx_cnt = 0;
                    if (rx_byte == CMD_READ_SCRATCH) begin
                        reading = 1'b1;
                        rd_idx  = 0;
                    end
                end
            end
            low_cnt = 0;
        end
        #1 slave_low = pull_left != 0;
    end

    function automatic logic [7:0] crc8_bytes(input logic [63:0] data);
        logic [7:0] crc;
        logic [7:0] b;
        crc = 8'd0;
        for (int i = 0; i < 8; i++) begin
            b = data[i*8 +: 8];
            for (int j = 0; j < 8; j++)
                crc = (crc[0] ^ b[j]) ? ((crc >> 1) ^ 8'h8C) : (crc >> 1);
        end
        return crc;
    endfunction

    task automatic load_scratch(input logic bad_crc);
        logic [31:0] rnd;
        logic [63:0] data;
        logic [7:0]  crc;
        rnd  = $random(seed);
        data = {8'h10, 8'h0C, 8'hFF, 8'h7F, 8'h46, 8'h4B, rnd[15:0]};
        crc  = crc8_bytes(data);
        if (bad_crc)
            crc = crc ^ 8'h10;
        scratch = {crc, data};
    endtask

    // ********************************************************************
    // Stimulus and waits
    // ********************************************************************
    task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (exp !== act) begin
            fail_cnt++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic pulse_request();
        @(posedge clk);
        #1 read_request = 1'b1;
        @(posedge clk);
        #1 read_request = 1'b0;
    endtask

    task automatic wait_result();
        int n;
        n = 0;
        while (!(temp_valid || no_device) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            timeouts++;
            $display("Timeout, no result pulse within %0d cycles", WAIT_LIMIT);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic check_commands();
        logic [7:0] exp_cmd [4];
        exp_cmd = '{CMD_SKIP_ROM, CMD_CONVERT_T, CMD_SKIP_ROM, CMD_READ_SCRATCH};
        if (cmd_log.size() != 4) begin
            fail_cnt++;
            $display("Sensor model received %0d command bytes instead of 4", cmd_log.size());
        end else begin
            for (int i = 0; i < 4; i++)
                check_value("command byte", {8'd0, exp_cmd[i]}, {8'd0, cmd_log[i]});
        end
    endtask

    task automatic run_read();
        cmd_log.delete();
        pulse_request();
        check_value("busy", 16'd1, {15'd0, busy});  // Rises once the request is taken
        wait_result();
        if (present)
            check_commands();
    endtask

    initial begin
        seed         = 32'h11211fee;
        rst          = 1'b1;
        read_request = 1'b0;
        present      = 1'b1;
        fail_cnt     = 0;
        timeouts     = 0;
        load_scratch(1'b0);
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;

        @(negedge clk);
        check_value("busy", 16'd0, {15'd0, busy});
        check_value("temp_valid", 16'd0, {15'd0, temp_valid});
        check_value("crc_error", 16'd0, {15'd0, crc_error});
        check_value("no_device", 16'd0, {15'd0, no_device});
        check_value("dq_drive_low", 16'd0, {15'd0, dq_drive_low});

        run_read();
        repeat (20) begin
            load_scratch(1'b0);
            run_read();
        end
        load_scratch(1'b1);  // One flipped bit in the CRC byte
        run_read();

        present = 1'b0;
        run_read();
        present = 1'b1;

        // Second request lands while the first is still running
        load_scratch(1'b0);
        results_before = results;
        pulse_request();
        repeat (20) @(posedge clk);
        pulse_request();
        wait_result();
        repeat (200) @(posedge clk);
        #1;
        check_value("busy", 16'd0, {15'd0, busy});
        if (results != results_before + 1) begin
            fail_cnt++;
            $display("Expected one result pulse, saw %0d", results - results_before);
        end

        $display("Checks %0d, mismatches %0d, other errors %0d, timeouts %0d",
                 checks, mismatches, fail_cnt, timeouts);
        if (mismatches == 0 && fail_cnt == 0 && timeouts == 0 && checks > 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

//--- testbench/temp_checker.sv
`timescale 1ns/1ps

module temp_checker import ds18b20_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    present,      // Sensor model on the bus
    input  logic [SCRATCH_BITS-1:0] scratch,      // Model scratchpad with byte 0 in the low bits
    input  logic                    busy,
    input  logic                    temp_valid,
    input  logic                    crc_error,
    input  logic [15:0]             temperature,
    input  logic                    no_device,
    output int                      checks,
    output int                      mismatches,
    output int                      results
);

    logic [16:0] expected;

    // Returns {crc_error, temperature} for a scratchpad as sent on the wire
    function automatic logic [16:0] expected_result(input logic [SCRATCH_BITS-1:0] pad);
        logic [7:0] crc;
        crc = 8'd0;
        for (int i = 0; i < SCRATCH_BITS - 8; i++) begin
            if (crc[0] ^ pad[i])
                crc = (crc >> 1) ^ 8'h8C;
            else
                crc = crc >> 1;
        end
        // Byte 8 carries the CRC of bytes 0 to 7
        return {crc != pad[SCRATCH_BITS-1 -: 8], pad[15:0]};
    endfunction

    task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
        checks = checks + 1;
        if (exp !== act) begin
            mismatches = mismatches + 1;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    // ********************************************************************
    // Result pulses sampled away from the active edge
    // ********************************************************************
    always @(negedge clk) begin
        if (rst) begin
            checks     = 0;
            mismatches = 0;
            results    = 0;
        end else begin
            if (temp_valid || no_device) begin
                results = results + 1;
                compare("busy", 16'd0, {15'd0, busy});  // Falls with the pulse
            end
            if (no_device)
                compare("no_device", {15'd0, ~present}, {15'd0, no_device});
            if (temp_valid && !present) begin
                mismatches = mismatches + 1;
                $display("temp_valid pulsed although no device is on the bus");
            end else if (temp_valid) begin
                expected = expected_result(scratch);
                compare("temperature", expected[15:0], temperature);
                compare("crc_error", {15'd0, expected[16]}, {15'd0, crc_error});
            end
            if (crc_error && !temp_valid) begin
                mismatches = mismatches + 1;
                $display("crc_error pulsed without temp_valid");
            end
        end
    end

endmodule
